// File: verilog/bridge_pkg.sv
/* Shared widths, FIFO depth, AXI response codes and the request and
   response structs of the AXI-to-APB bridge */
package bridge_pkg;

    localparam int ADDR_WIDTH  = 32;
    localparam int DATA_WIDTH  = 32;
    localparam int ID_WIDTH    = 4;
    localparam int FIFO_DEPTH  = 4;
    localparam int SLAVE_COUNT = 8;
    // Slave index comes from the top address bits
    localparam int SEL_WIDTH   = $clog2(SLAVE_COUNT);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // AW and AR queue entry
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [ID_WIDTH-1:0]   id;
    } addr_cmd_t;

    // W queue entry
    typedef logic [DATA_WIDTH-1:0] wdata_t;

    typedef struct packed {
        logic                  write;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
        logic [ID_WIDTH-1:0]   id;
    } apb_req_t;

    typedef struct packed {
        logic                  write;
        logic [ID_WIDTH-1:0]   id;
        logic [DATA_WIDTH-1:0] rdata;
        logic                  err;
    } apb_rsp_t;

endpackage

// File: verilog/bridge_ifs.sv
/* Request and response handshake interfaces between the arbiter,
   the APB master and the response router */
`timescale 1ns/1ns

interface apb_req_if import bridge_pkg::*; ();
    logic                  valid;
    logic                  ready;
    logic                  write;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
    logic [ID_WIDTH-1:0]   id;

    modport source (output valid, write, addr, wdata, id, input ready);
    modport sink (input valid, write, addr, wdata, id, output ready);
endinterface

interface apb_rsp_if import bridge_pkg::*; ();
    logic                  valid;
    logic                  ready;
    logic                  write;
    logic [ID_WIDTH-1:0]   id;
    logic [DATA_WIDTH-1:0] rdata;
    logic                  err;

    // Master produces results, router consumes them
    modport source (output valid, write, id, rdata, err, input ready);
    modport sink (input valid, write, id, rdata, err, output ready);
endinterface

// File: verilog/req_fifo.sv
/* Show-ahead FIFO with wrap-bit pointers and a typed payload */
`timescale 1ns/1ns

module req_fifo import bridge_pkg::*; #(
    parameter type item_t = logic,
    parameter int  depth  = FIFO_DEPTH
) (
    input  logic  clk,
    input  logic  preset_n,
    input  logic  push_valid,
    input  item_t push_data,
    output logic  push_ready,
    output logic  pop_valid,
    output item_t pop_data,
    input  logic  pop_ready
);

    localparam int PTR_W = $clog2(depth);

    item_t          mem [depth];
    // Extra top bit tells full from empty when indices match
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;
    logic           full;
    logic           empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    assign push_ready = !full;
    assign pop_valid  = !empty;
    assign pop_data   = mem[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge clk) begin
        if (push_valid && push_ready) begin
            mem[wr_ptr[PTR_W-1:0]] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!preset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_valid && push_ready) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_valid && pop_ready) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// File: verilog/axi_req_arbiter.sv
/* Write/read arbiter: joins AW and W heads into one write request
   and alternates writes with reads toward the APB master */
`timescale 1ns/1ns

module axi_req_arbiter import bridge_pkg::*; (
    input  logic             clk,
    input  logic             preset_n,
    input  logic             aw_valid,
    input  addr_cmd_t        aw_cmd,
    output logic             aw_pop,
    input  logic             w_valid,
    input  wdata_t           w_data,
    output logic             w_pop,
    input  logic             ar_valid,
    input  addr_cmd_t        ar_cmd,
    output logic             ar_pop,
    apb_req_if.source        req
);

    logic wr_avail;
    logic rd_avail;
    logic grant_write;
    logic fire;
    // Set when the last granted request was a write
    logic last_write;

    // A write needs both its address and its data
    assign wr_avail = aw_valid && w_valid;
    assign rd_avail = ar_valid;

    // On contention the kind not served last time wins
    assign grant_write = wr_avail && (!rd_avail || !last_write);

    assign req.valid = wr_avail || rd_avail;
    assign req.write = grant_write;
    assign req.addr  = grant_write ? aw_cmd.addr : ar_cmd.addr;
    assign req.id    = grant_write ? aw_cmd.id : ar_cmd.id;
    assign req.wdata = w_data;

    assign fire   = req.valid && req.ready;
    assign aw_pop = fire && grant_write;
    assign w_pop  = fire && grant_write;
    assign ar_pop = fire && !grant_write;

    always_ff @(posedge clk) begin
        if (!preset_n) begin
            last_write <= 1'b0;
        end else if (fire) begin
            last_write <= grant_write;
        end
    end

endmodule

// File: verilog/apb_master.sv
/* APB master FSM: idle, setup, access and respond, with one-hot
   slave select decoded from the top address bits */
`timescale 1ns/1ns

module apb_master import bridge_pkg::*; (
    input  logic                   clk,
    input  logic                   preset_n,
    apb_req_if.sink                req,
    apb_rsp_if.source              rsp,
    output logic [SLAVE_COUNT-1:0] psel,
    output logic                   penable,
    output logic                   pwrite,
    output logic [ADDR_WIDTH-1:0]  paddr,
    output logic [DATA_WIDTH-1:0]  pwdata,
    input  logic [DATA_WIDTH-1:0]  prdata,
    input  logic                   pready,
    input  logic                   pslverr
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS,
        ST_RESPOND
    } state_t;

    state_t         state;
    apb_req_t       cur_req;
    logic [DATA_WIDTH-1:0] rdata_q;
    logic           err_q;
    logic [SEL_WIDTH-1:0]  slave_idx;

    assign req.ready = (state == ST_IDLE);

    assign slave_idx = cur_req.addr[ADDR_WIDTH-1 -: SEL_WIDTH];
    assign psel      = (state == ST_SETUP || state == ST_ACCESS) ?
                       (SLAVE_COUNT'(1) << slave_idx) : '0;
    assign penable   = (state == ST_ACCESS);
    assign pwrite    = cur_req.write;
    assign paddr     = cur_req.addr;
    assign pwdata    = cur_req.wdata;

    // Result held until the router takes it
    assign rsp.valid = (state == ST_RESPOND);
    assign rsp.write = cur_req.write;
    assign rsp.id    = cur_req.id;
    assign rsp.rdata = rdata_q;
    assign rsp.err   = err_q;

    always_ff @(posedge clk) begin
        if (!preset_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req.valid) begin
                        state <= ST_SETUP;
                    end
                end
                ST_SETUP: state <= ST_ACCESS;
                ST_ACCESS: begin
                    if (pready) begin
                        state <= ST_RESPOND;
                    end
                end
                ST_RESPOND: begin
                    if (rsp.ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid && req.ready) begin
            cur_req <= '{write: req.write, addr: req.addr, wdata: req.wdata, id: req.id};
        end
        // Sample slave result on completion of access
        if (state == ST_ACCESS && pready) begin
            rdata_q <= prdata;
            err_q   <= pslverr;
        end
    end

endmodule

// File: verilog/axi_resp_router.sv
/* One-entry response slot steering APB results to the B or R channel */
`timescale 1ns/1ns

module axi_resp_router import bridge_pkg::*; (
    input  logic                  clk,
    input  logic                  preset_n,
    apb_rsp_if.sink               rsp,
    output logic                  bvalid,
    output logic [1:0]            bresp,
    output logic [ID_WIDTH-1:0]   bid,
    input  logic                  bready,
    output logic                  rvalid,
    output logic [1:0]            rresp,
    output logic [ID_WIDTH-1:0]   rid,
    output logic [DATA_WIDTH-1:0] rdata,
    output logic                  rlast,
    input  logic                  rready
);

    logic     full;
    apb_rsp_t slot;
    logic [1:0] resp_code;

    assign rsp.ready = !full;

    assign resp_code = slot.err ? RESP_SLVERR : RESP_OKAY;

    assign bvalid = full && slot.write;
    assign bresp  = resp_code;
    assign bid    = slot.id;

    assign rvalid = full && !slot.write;
    assign rresp  = resp_code;
    assign rid    = slot.id;
    assign rdata  = slot.rdata;
    // Single-beat reads only
    assign rlast  = rvalid;

    always_ff @(posedge clk) begin
        if (!preset_n) begin
            full <= 1'b0;
        end else if (rsp.valid && rsp.ready) begin
            full <= 1'b1;
        end else if ((bvalid && bready) || (rvalid && rready)) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp.valid && rsp.ready) begin
            slot <= '{write: rsp.write, id: rsp.id, rdata: rsp.rdata, err: rsp.err};
        end
    end

endmodule

// File: verilog/axi_apb_bridge.sv
/* AXI-to-APB bridge top: AW, W and AR queues, arbiter, APB master
   and response router */
`timescale 1ns/1ns

module axi_apb_bridge import bridge_pkg::*; (
    input  logic                   clk,
    input  logic                   preset_n,
    // AXI write address
    input  logic [ADDR_WIDTH-1:0]  awaddr,
    input  logic [ID_WIDTH-1:0]    awid,
    input  logic                   awvalid,
    output logic                   awready,
    // AXI write data, wlast ignored for single beats
    input  logic [DATA_WIDTH-1:0]  wdata,
    input  logic                   wlast,
    input  logic                   wvalid,
    output logic                   wready,
    output logic                   bvalid,
    output logic [1:0]             bresp,
    output logic [ID_WIDTH-1:0]    bid,
    input  logic                   bready,
    input  logic [ADDR_WIDTH-1:0]  araddr,
    input  logic [ID_WIDTH-1:0]    arid,
    input  logic                   arvalid,
    output logic                   arready,
    output logic                   rvalid,
    output logic [1:0]             rresp,
    output logic [ID_WIDTH-1:0]    rid,
    output logic [DATA_WIDTH-1:0]  rdata,
    output logic                   rlast,
    input  logic                   rready,
    // APB
    output logic [SLAVE_COUNT-1:0] psel,
    output logic                   penable,
    output logic                   pwrite,
    output logic [ADDR_WIDTH-1:0]  paddr,
    output logic [DATA_WIDTH-1:0]  pwdata,
    input  logic [DATA_WIDTH-1:0]  prdata,
    input  logic                   pready,
    input  logic                   pslverr
);

    addr_cmd_t aw_head, ar_head;
    wdata_t    w_head;
    logic      aw_nonempty, w_nonempty, ar_nonempty;
    logic      aw_pop, w_pop, ar_pop;

    apb_req_if req_bus ();
    apb_rsp_if rsp_bus ();

    req_fifo #(.item_t(addr_cmd_t)) u_aw_fifo (
        .clk(clk), .preset_n(preset_n),
        .push_valid(awvalid), .push_data('{addr: awaddr, id: awid}), .push_ready(awready),
        .pop_valid(aw_nonempty), .pop_data(aw_head), .pop_ready(aw_pop)
    );

    req_fifo #(.item_t(wdata_t)) u_w_fifo (
        .clk(clk), .preset_n(preset_n),
        .push_valid(wvalid), .push_data(wdata), .push_ready(wready),
        .pop_valid(w_nonempty), .pop_data(w_head), .pop_ready(w_pop)
    );

    req_fifo #(.item_t(addr_cmd_t)) u_ar_fifo (
        .clk(clk), .preset_n(preset_n),
        .push_valid(arvalid), .push_data('{addr: araddr, id: arid}), .push_ready(arready),
        .pop_valid(ar_nonempty), .pop_data(ar_head), .pop_ready(ar_pop)
    );

    axi_req_arbiter u_arbiter (
        .clk(clk), .preset_n(preset_n),
        .aw_valid(aw_nonempty), .aw_cmd(aw_head), .aw_pop(aw_pop),
        .w_valid(w_nonempty), .w_data(w_head), .w_pop(w_pop),
        .ar_valid(ar_nonempty), .ar_cmd(ar_head), .ar_pop(ar_pop),
        .req(req_bus.source)
    );

    apb_master u_apb_master (
        .clk(clk), .preset_n(preset_n),
        .req(req_bus.sink), .rsp(rsp_bus.source),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    axi_resp_router u_resp_router (
        .clk(clk), .preset_n(preset_n),
        .rsp(rsp_bus.sink),
        .bvalid(bvalid), .bresp(bresp), .bid(bid), .bready(bready),
        .rvalid(rvalid), .rresp(rresp), .rid(rid), .rdata(rdata),
        .rlast(rlast), .rready(rready)
    );

endmodule

// File: verif/apb_slave_mem.sv
/* APB slave model with a 64-word memory, random wait states and
   error responses for addresses with bit 8 set */
`timescale 1ns/1ns

module apb_slave_mem import bridge_pkg::*; (
    input  logic                   clk,
    input  logic                   preset_n,
    input  logic [SLAVE_COUNT-1:0] psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [ADDR_WIDTH-1:0]  paddr,
    input  logic [DATA_WIDTH-1:0]  pwdata,
    output logic [DATA_WIDTH-1:0]  prdata,
    output logic                   pready,
    output logic                   pslverr
);

    logic [DATA_WIDTH-1:0] mem [64];
    logic [1:0]            wait_cnt;

    assign pready  = (psel != '0) && penable && (wait_cnt == 2'd0);
    assign pslverr = paddr[8];
    assign prdata  = mem[paddr[7:2]];

    always @(posedge clk) begin
        if (!preset_n) begin
            wait_cnt <= 2'd0;
            // Initial contents depend on the word index
            for (int i = 0; i < 64; i++) begin
                mem[i] <= 32'h3c00_0000 ^ (i * 32'h0001_0405);
            end
        end else begin
            if (psel != '0 && !penable) begin
                wait_cnt <= 2'($urandom_range(3, 0));
            end else if (penable && wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end
            // Error writes leave the memory alone
            if (pready && pwrite && !paddr[8]) begin
                mem[paddr[7:2]] <= pwdata;
            end
        end
    end

endmodule

// File: verif/tb_axi_apb_bridge.sv
/* Bridge testbench with clock, reset, random AXI traffic, memory mirror,
   APB monitor and five tests with a closing report */
`timescale 1ns/1ns

module tb_axi_apb_bridge import bridge_pkg::*; ();

    localparam int WAIT_LIMIT = 200;
    localparam int CH_AW = 0;
    localparam int CH_W  = 1;
    localparam int CH_AR = 2;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        logic [ID_WIDTH-1:0]   id;
        logic [1:0]            resp;
    } xfer_t;

    logic clk;
    logic preset_n;
    logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rlast, rready;
    logic penable, pwrite, pready, pslverr;
    logic [ADDR_WIDTH-1:0]  awaddr, araddr, paddr;
    logic [DATA_WIDTH-1:0]  wdata, rdata, pwdata, prdata;
    logic [ID_WIDTH-1:0]    awid, bid, arid, rid;
    logic [1:0]             bresp, rresp;
    logic [SLAVE_COUNT-1:0] psel;

    // Memory mirror and expected traffic
    logic [DATA_WIDTH-1:0] model_mem [64];
    xfer_t                 wr_list[$];
    xfer_t                 rd_list[$];
    int                    errors = 0;
    int                    mon_errors = 0;
    int                    failed_tests = 0;
    int                    setup_count = 0;
    logic                  track_req;
    logic                  exp_write;
    logic [ADDR_WIDTH-1:0] exp_addr;
    logic [DATA_WIDTH-1:0] exp_wdata;
    logic                  psel_was_on = 1'b0;

    axi_apb_bridge u_axi_apb_bridge (.*);
    apb_slave_mem u_slave_mem (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] got,
                               input logic [DATA_WIDTH-1:0] exp);
        assert (got === exp) else begin
            $display("error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [ADDR_WIDTH-1:0] make_addr(input logic [5:0] idx, input logic err);
        logic [31:0] r;
        r = $urandom;
        return {r[31:9], err, idx, 2'b00};
    endfunction

    // Applies one access to the mirror and gives the expected response
    function automatic xfer_t model_access(input logic is_write, input logic [ADDR_WIDTH-1:0] addr,
                                           input logic [DATA_WIDTH-1:0] data);
        xfer_t x;
        x.addr = addr;
        x.id   = ID_WIDTH'($urandom);
        x.resp = addr[8] ? RESP_SLVERR : RESP_OKAY;
        x.data = is_write ? data : model_mem[addr[7:2]];
        if (is_write && !addr[8]) begin
            model_mem[addr[7:2]] = data;
        end
        return x;
    endfunction

    function automatic logic chan_ready(input int chan);
        case (chan)
            CH_AW: return awready;
            CH_W: return wready;
            default: return arready;
        endcase
    endfunction

    task automatic push_req(input int chan, input logic [ADDR_WIDTH-1:0] addr,
                            input logic [ID_WIDTH-1:0] id, input logic [DATA_WIDTH-1:0] data);
        int n;
        n = 0;
        case (chan)
            CH_AW: begin
                awaddr  = addr;
                awid    = id;
                awvalid = 1'b1;
            end
            CH_W: begin
                wdata  = data;
                wvalid = 1'b1;
            end
            default: begin
                araddr  = addr;
                arid    = id;
                arvalid = 1'b1;
            end
        endcase
        while (!chan_ready(chan) && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        assert (chan_ready(chan)) else begin
            $display("timeout: request channel %0d never accepted a transfer", chan);
            errors++;
        end
        tick();
        case (chan)
            CH_AW: awvalid = 1'b0;
            CH_W: wvalid = 1'b0;
            default: arvalid = 1'b0;
        endcase
    endtask

    // Waits for one B or R response with optional random ready
    task automatic recv_rsp(input logic is_read, input xfer_t exp, input logic rand_rdy);
        int n;
        logic seen;
        logic done;
        logic vld;
        logic rdy;
        logic [ID_WIDTH+DATA_WIDTH+2:0] held;
        logic [ID_WIDTH+DATA_WIDTH+2:0] cur;
        n = 0;
        seen = 1'b0;
        done = 1'b0;
        held = '0;
        while (!done && n < WAIT_LIMIT) begin
            rdy = rand_rdy ? ($urandom_range(1, 0) == 1) : 1'b1;
            if (is_read) begin
                rready = rdy;
                vld = rvalid;
                cur = {rid, rresp, rdata, rlast};
            end else begin
                bready = rdy;
                vld = bvalid;
                cur = {bid, bresp, 32'h0, 1'b0};
            end
            if (seen) begin
                assert (vld) else begin
                    $display("%s dropped before the response was accepted",
                             is_read ? "rvalid" : "bvalid");
                    errors++;
                    seen = 1'b0;
                end
            end
            if (vld && seen) begin
                assert (cur === held) else begin
                    $display("error %s payload changed while valid: %h, then %h",
                             is_read ? "rvalid" : "bvalid", held, cur);
                    errors++;
                end
            end
            if (vld && rdy) begin
                if (is_read) begin
                    check_value("rid", 32'(rid), 32'(exp.id));
                    check_value("rresp", 32'(rresp), 32'(exp.resp));
                    check_value("rlast", 32'(rlast), 32'd1);
                    if (exp.resp == RESP_OKAY) begin
                        check_value("rdata", rdata, exp.data);
                    end
                end else begin
                    check_value("bid", 32'(bid), 32'(exp.id));
                    check_value("bresp", 32'(bresp), 32'(exp.resp));
                end
                done = 1'b1;
            end else if (vld) begin
                seen = 1'b1;
                held = cur;
            end
            tick();
            n++;
        end
        if (is_read) begin
            rready = 1'b0;
        end else begin
            bready = 1'b0;
        end
        assert (done) else begin
            $display("timeout: no %s response arrived", is_read ? "read" : "write");
            errors++;
        end
    endtask

    // One request at a time with its response taken before returning
    task automatic run_serial(input logic is_write, input logic [ADDR_WIDTH-1:0] addr,
                              input logic [DATA_WIDTH-1:0] data);
        xfer_t x;
        x = model_access(is_write, addr, data);
        exp_addr  = addr;
        exp_write = is_write;
        exp_wdata = data;
        if (is_write) begin
            push_req(CH_AW, addr, x.id, '0);
            push_req(CH_W, '0, '0, data);
        end else begin
            push_req(CH_AR, addr, x.id, '0);
        end
        recv_rsp(!is_write, x, 1'b0);
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        int n;
        n = errors + mon_errors - err_before;
        if (n == 0) begin
            $display("test %0d %s: pass", num, name);
        end else begin
            $display("test %0d %s: fail, %0d failed checks", num, name, n);
            failed_tests++;
        end
    endtask

    // APB monitor sampled on the falling clock edge
    always @(negedge clk) begin
        if (!preset_n) begin
            psel_was_on = 1'b0;
        end else begin
            if (psel != '0) begin
                assert ($onehot(psel) && psel[paddr[31:29]]) else begin
                    $display("error psel %h does not match paddr %h", psel, paddr);
                    mon_errors++;
                end
                assert (penable == psel_was_on) else begin
                    $display("error penable %h, expected %h", penable, psel_was_on);
                    mon_errors++;
                end
                if (!penable) begin
                    setup_count++;
                end
                if (track_req) begin
                    assert (paddr == exp_addr && pwrite == exp_write &&
                            (!exp_write || pwdata == exp_wdata)) else begin
                        $display("error paddr %h pwrite %h pwdata %h, expected %h %h %h",
                                 paddr, pwrite, pwdata, exp_addr, exp_write, exp_wdata);
                        mon_errors++;
                    end
                end
            end
            psel_was_on = (psel != '0);
        end
    end

    initial begin
        logic [ADDR_WIDTH-1:0] addrs [8];
        logic [ADDR_WIDTH-1:0] a;
        xfer_t x;
        int e0;
        int n0;
        void'($urandom(32'h9764_88a2));
        preset_n  = 1'b0;
        awaddr    = '0;
        awid      = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wlast     = 1'b1;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arid      = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        track_req = 1'b1;
        exp_write = 1'b0;
        exp_addr  = '0;
        exp_wdata = '0;
        for (int i = 0; i < 64; i++) begin
            model_mem[i] = 32'h3c00_0000 ^ (i * 32'h0001_0405);
        end
        tick();
        tick();
        preset_n = 1'b1;
        tick();

        e0 = errors + mon_errors;
        for (int i = 0; i < 8; i++) begin
            addrs[i] = make_addr(6'($urandom), 1'b0);
            run_serial(1'b1, addrs[i], $urandom);
        end
        for (int i = 0; i < 8; i++) begin
            run_serial(1'b0, addrs[i], '0);
        end
        report_test(1, "write then read", e0);

        e0 = errors + mon_errors;
        for (int i = 0; i < 4; i++) begin
            a = make_addr(6'($urandom), 1'b1);
            run_serial(1'b1, a, $urandom);
            run_serial(1'b0, a, '0);
            // Same word without the error bit still holds old data
            run_serial(1'b0, {a[31:9], 1'b0, a[7:0]}, '0);
        end
        report_test(2, "slave error", e0);

        e0 = errors + mon_errors;
        n0 = setup_count;
        for (int i = 0; i < 16; i++) begin
            a = make_addr(6'($urandom), $urandom_range(1, 0) == 1);
            run_serial($urandom_range(1, 0) == 1, a, $urandom);
        end
        check_value("setup_count", 32'(setup_count - n0), 32'd16);
        report_test(3, "slave select", e0);

        // Writes and reads hit disjoint words so order between them is free
        e0 = errors + mon_errors;
        track_req = 1'b0;
        wr_list.delete();
        rd_list.delete();
        for (int i = 0; i < 12; i++) begin
            a = make_addr(6'($urandom_range(15, 0)), $urandom_range(1, 0) == 1);
            wr_list.push_back(model_access(1'b1, a, $urandom));
            a = make_addr(6'(32 + $urandom_range(15, 0)), $urandom_range(1, 0) == 1);
            rd_list.push_back(model_access(1'b0, a, '0));
        end
        fork
            foreach (wr_list[i]) begin
                push_req(CH_AW, wr_list[i].addr, wr_list[i].id, '0);
                push_req(CH_W, '0, '0, wr_list[i].data);
            end
            foreach (rd_list[i]) begin
                push_req(CH_AR, rd_list[i].addr, rd_list[i].id, '0);
            end
            foreach (wr_list[i]) begin
                recv_rsp(1'b0, wr_list[i], 1'b1);
            end
            foreach (rd_list[i]) begin
                recv_rsp(1'b1, rd_list[i], 1'b1);
            end
        join
        repeat (6) begin
            tick();
            assert (!bvalid && !rvalid) else begin
                $display("extra response seen after all expected ones were taken");
                errors++;
            end
        end
        report_test(4, "back-pressure", e0);

        e0 = errors + mon_errors;
        wr_list.delete();
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            a = make_addr(6'($urandom), $urandom_range(1, 0) == 1);
            x = model_access(1'b1, a, $urandom);
            wr_list.push_back(x);
            push_req(CH_AW, x.addr, x.id, '0);
        end
        check_value("awready", 32'(awready), 32'd0);
        repeat (8) begin
            tick();
            check_value("awready", 32'(awready), 32'd0);
        end
        foreach (wr_list[i]) begin
            push_req(CH_W, '0, '0, wr_list[i].data);
        end
        foreach (wr_list[i]) begin
            recv_rsp(1'b0, wr_list[i], 1'b0);
        end
        report_test(5, "fifo full", e0);

        $display("summary: 5 tests, %0d failed, %0d failed checks",
                 failed_tests, errors + mon_errors);
        if (errors + mon_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: src.f
verilog/bridge_pkg.sv
verilog/bridge_ifs.sv
verilog/req_fifo.sv
verilog/axi_req_arbiter.sv
verilog/apb_master.sv
verilog/axi_resp_router.sv
verilog/axi_apb_bridge.sv
verif/apb_slave_mem.sv
verif/tb_axi_apb_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the bridge testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert --top-module tb_axi_apb_bridge \
    -f src.f --Mdir obj_dir -o sim_tb > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    cat "$build_log"
    echo "Build failed"
    exit 1
fi

./obj_dir/sim_tb > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" "$sim_log"; then
    exit 0
fi
exit 1
